// ==== flist.f ====
dbg_pkg.sv
bin_to_dec_ascii.sv
report_timer.sv
cmd_decoder.sv
msg_sender.sv
debug_terminal.sv
debug_terminal_assertions.sv
tb_debug_terminal.sv

// ==== Makefile ====
# Verilator simulation of the debug terminal testbench

VERILATOR ?= verilator
TOP       ?= tb_debug_terminal
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIMFLAGS  ?= +verilator+error+limit+100
PASS_MSG  ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_debug_terminal.sv ====
// Debug terminal testbench
// Table-driven commands and acc values, random tx_busy back-pressure,
// every status line captured and compared with a model of the layout
`timescale 1ns/1ps
`default_nettype none

module tb_debug_terminal;

  import dbg_pkg::*;

  localparam int REPORT_CYCLES = 400;
  localparam int TS_CYCLES     = 4;
  localparam int TS_PER_REPORT = REPORT_CYCLES / TS_CYCLES;
  localparam int RESET_CYCLES  = 10;
  localparam int NUM_ROWS      = 12;

  // Stimulus row where a zero cmd sends nothing
  typedef struct packed {
    logic [7:0]           cmd;
    logic [15:0]          wait_cycles;
    logic [ACC_WIDTH-1:0] acc;
  } stim_row_t;

  logic                 clk;
  logic                 rst;
  logic [ACC_WIDTH-1:0] acc;
  logic [7:0]           rx_data;
  logic                 new_rx_data;
  logic                 tx_busy;
  logic [7:0]           tx_data;
  logic                 new_tx_data;
  logic                 board_reset;

  stim_row_t   rows [NUM_ROWS];
  logic [31:0] rand_state;
  int unsigned timeout_limit;
  int unsigned cycle_count;
  int          errors;
  int          lines_checked;

  // Monitor state
  logic [7:0] cur_line [$];
  logic [7:0] done_line [$];
  int         lines_started;
  int         lines_done;
  int         reset_cycles_seen;

  // Model state
  logic model_motor;
  logic model_logging;
  int   expected_pulses;

  debug_terminal #(
    .REPORT_CYCLES (REPORT_CYCLES),
    .TS_CYCLES     (TS_CYCLES)
  ) debug_terminal_inst (
    .clk         (clk),
    .rst         (rst),
    .acc         (acc),
    .rx_data     (rx_data),
    .new_rx_data (new_rx_data),
    .tx_busy     (tx_busy),
    .tx_data     (tx_data),
    .new_tx_data (new_tx_data),
    .board_reset (board_reset)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Decimal digit at position pos with 0 as the units
  function automatic int decimal_digit(input int unsigned value, input int pos);
    int unsigned scale;
    scale = 1;
    for (int k = 0; k < pos; k++) begin
      scale = scale * 10;
    end
    return (value / scale) % 10;
  endfunction

  // Reference text of one status line
  function automatic string expected_line(input logic motor, input logic logging,
                                          input int unsigned ts,
                                          input logic [15:0] acc_val);
    return $sformatf(" %s %s T: %0d%0d%0d.%0d %b %b\r",
                     motor ? "A" : "D", logging ? "R" : "I",
                     decimal_digit(ts, 5), decimal_digit(ts, 4),
                     decimal_digit(ts, 3), decimal_digit(ts, 2),
                     acc_val[15:8], acc_val[7:0]);
  endfunction

  // Random back-pressure about one cycle in four
  always @(posedge clk) begin
    #1;
    rand_state = xorshift32(rand_state);
    tx_busy    = (rand_state[1:0] == 2'b00);
  end

  // Run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_limit) begin
      $display("Timeout: run did not finish within %0d cycles", timeout_limit);
      $display("tests failed");
      $finish;
    end
  end

  // Byte and pulse monitor on the falling edge where outputs are settled
  always @(negedge clk) begin
    if (rst) begin
      // Outputs are known only after the first reset edge
      if (cycle_count > 0) begin
        assert (!new_tx_data && !board_reset) else begin
          errors++;
          $display("[FAIL] %0t: output strobe active during reset", $time);
        end
      end
    end else begin
      if (new_tx_data) begin
        assert (!tx_busy) else begin
          errors++;
          $display("[FAIL] %0t: byte sent while tx_busy high", $time);
        end
        if (cur_line.size() == 0) begin
          lines_started++;
        end
        cur_line.push_back(tx_data);
        // CR closes the line
        if (tx_data == 8'h0d) begin
          done_line = cur_line;
          cur_line.delete();
          lines_done++;
        end
      end
      if (board_reset) begin
        reset_cycles_seen++;
      end
    end
  end

  // One command byte then idle past the action cycle
  task automatic send_cmd(input logic [7:0] c);
    @(posedge clk);
    #1;
    rx_data     = c;
    new_rx_data = 1'b1;
    @(posedge clk);
    #1;
    rx_data     = 8'h00;
    new_rx_data = 1'b0;
    repeat (2) @(posedge clk);
    case (c)
      CMD_MOTOR: model_motor = ~model_motor;
      CMD_DATA:  model_logging = ~model_logging;
      CMD_RESET: expected_pulses++;
      default:   ;
    endcase
  endtask

  // Compare the last captured line with the reference text
  task automatic check_line(input string exp, input int n);
    int    first_bad;
    string got;
    first_bad = -1;
    got       = "";
    assert (done_line.size() == MSG_LEN) else begin
      errors++;
      $display("[FAIL] %0t: line %0d has %0d bytes, expected %0d",
               $time, n, done_line.size(), MSG_LEN);
    end
    for (int k = 0; k < done_line.size(); k++) begin
      if (k < MSG_LEN - 1) begin
        got = $sformatf("%s%c", got, done_line[k]);
      end
      if ((first_bad < 0) && ((k >= exp.len()) || (done_line[k] != exp[k]))) begin
        first_bad = k;
      end
    end
    assert (first_bad < 0) else begin
      errors++;
      $display("[FAIL] %0t: line %0d differs at char %0d: got \"%s\" expected \"%s\"",
               $time, n, first_bad, got, exp.substr(0, MSG_LEN - 2));
    end
    lines_checked++;
  endtask

  // Apply one row and check the line of the report that follows
  task automatic run_row(input int i);
    stim_row_t row;
    string     exp;
    row = rows[i];
    @(posedge clk);
    #1;
    acc = row.acc;
    if (row.cmd != 8'h00) begin
      send_cmd(row.cmd);
    end
    repeat (row.wait_cycles) @(posedge clk);
    exp = expected_line(model_motor, model_logging,
                        (i + 1) * TS_PER_REPORT - 1, row.acc);
    // Nothing may start before this report's tick
    assert (lines_started == i) else begin
      errors++;
      $display("[FAIL] %0t: %0d lines started before tick %0d, expected %0d",
               $time, lines_started, i + 1, i);
    end
    // Scramble acc once the line is under way
    while (lines_started <= i) @(posedge clk);
    #1;
    acc = ~row.acc;
    while (lines_done <= i) @(posedge clk);
    check_line(exp, i + 1);
    assert (reset_cycles_seen == expected_pulses) else begin
      errors++;
      $display("[FAIL] %0t: board_reset high for %0d cycles, expected %0d",
               $time, reset_cycles_seen, expected_pulses);
    end
  endtask

  initial begin
    int unsigned total_wait;
    rst         = 1'b1;
    acc         = '0;
    rx_data     = 8'h00;
    new_rx_data = 1'b0;
    tx_busy     = 1'b0;
    rand_state  = 32'h089a_099d;
    cycle_count = 0;
    errors      = 0;
    lines_checked     = 0;
    lines_started     = 0;
    lines_done        = 0;
    reset_cycles_seen = 0;
    model_motor     = 1'b0;
    model_logging   = 1'b0;
    expected_pulses = 0;

    // Commands include the unknown bytes x and q
    rows[0]  = '{cmd: 8'h00, wait_cycles: 16'd5,  acc: 16'hA55A};
    rows[1]  = '{cmd: "m",   wait_cycles: 16'd10, acc: 16'h0001};
    rows[2]  = '{cmd: "d",   wait_cycles: 16'd20, acc: 16'h8000};
    rows[3]  = '{cmd: "r",   wait_cycles: 16'd15, acc: 16'hFFFF};
    rows[4]  = '{cmd: "x",   wait_cycles: 16'd8,  acc: 16'h1234};
    rows[5]  = '{cmd: "m",   wait_cycles: 16'd30, acc: 16'h00FF};
    rows[6]  = '{cmd: 8'h00, wait_cycles: 16'd50, acc: 16'hFF00};
    rows[7]  = '{cmd: "d",   wait_cycles: 16'd12, acc: 16'h0F0F};
    rows[8]  = '{cmd: "r",   wait_cycles: 16'd25, acc: 16'hC3C3};
    rows[9]  = '{cmd: "q",   wait_cycles: 16'd40, acc: 16'h7E81};
    rows[10] = '{cmd: "m",   wait_cycles: 16'd60, acc: 16'hBEEF};
    rows[11] = '{cmd: "d",   wait_cycles: 16'd3,  acc: 16'h5AA5};

    total_wait = 0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      total_wait = total_wait + rows[i].wait_cycles;
    end
    timeout_limit = RESET_CYCLES + total_wait + 20 * REPORT_CYCLES;

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;

    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    repeat (5) @(posedge clk);

    $display("Summary: %0d lines checked, %0d errors", lines_checked, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== debug_terminal_assertions.sv ====
// Strobe and reset protocol checker
// Bound into the line sender and the command decoder, each instance
// sees only the signals of its own block
`timescale 1ns/1ps
`default_nettype none

module debug_terminal_assertions (
  input logic clk,
  input logic rst,
  input logic new_tx_data,
  input logic tx_busy,
  input logic board_reset
);

  // Byte strobe only when the bridge is free
  a_tx_not_busy: assert property (@(posedge clk) disable iff (rst)
    new_tx_data |-> !tx_busy)
    else $error("new_tx_data high while tx_busy high");

  // Board reset is a single-cycle pulse
  a_reset_pulse: assert property (@(posedge clk) disable iff (rst)
    board_reset |=> !board_reset)
    else $error("board_reset longer than one cycle");

  // Quiet outputs once reset has taken effect
  a_quiet_in_reset: assert property (@(posedge clk)
    (rst && $past(rst)) |-> (!new_tx_data && !board_reset))
    else $error("strobe active during reset");

endmodule

// Sender side, no board reset here
bind msg_sender debug_terminal_assertions sender_chk (
  .clk         (clk),
  .rst         (rst),
  .new_tx_data (new_tx_data),
  .tx_busy     (tx_busy),
  .board_reset (1'b0)
);

// Decoder side, no byte strobe here
bind cmd_decoder debug_terminal_assertions decoder_chk (
  .clk         (clk),
  .rst         (rst),
  .new_tx_data (1'b0),
  .tx_busy     (1'b0),
  .board_reset (board_reset)
);

`default_nettype wire

// ==== debug_terminal.sv ====
// Debug terminal top level
// Periodic status line to the serial bridge plus single-byte
// command handling for motor, logging and board reset
`timescale 1ns/1ps
`default_nettype none

module debug_terminal #(
  parameter int REPORT_CYCLES = 400,
  parameter int TS_CYCLES     = 4
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [dbg_pkg::ACC_WIDTH-1:0] acc,
  input  logic [7:0]                    rx_data,
  input  logic                          new_rx_data,
  input  logic                          tx_busy,
  output logic [7:0]                    tx_data,
  output logic                          new_tx_data,
  output logic                          board_reset
);

  import dbg_pkg::*;

  logic                   tick;
  logic [TS_WIDTH-1:0]    timestamp;
  logic [TS_DIGITS*8-1:0] ts_ascii;
  status_t                status;

  // Report tick and timestamp
  report_timer #(
    .REPORT_CYCLES (REPORT_CYCLES),
    .TS_CYCLES     (TS_CYCLES)
  ) report_timer_inst (
    .clk       (clk),
    .rst       (rst),
    .tick      (tick),
    .timestamp (timestamp)
  );

  // Timestamp as decimal text
  bin_to_dec_ascii #(
    .BITS   (TS_WIDTH),
    .DIGITS (TS_DIGITS)
  ) bin_to_dec_ascii_inst (
    .bin   (timestamp),
    .ascii (ts_ascii)
  );

  cmd_decoder cmd_decoder_inst (
    .clk         (clk),
    .rst         (rst),
    .rx_data     (rx_data),
    .new_rx_data (new_rx_data),
    .status      (status),
    .board_reset (board_reset)
  );

  msg_sender msg_sender_inst (
    .clk         (clk),
    .rst         (rst),
    .tick        (tick),
    .ts_ascii    (ts_ascii),
    .acc         (acc),
    .status      (status),
    .tx_busy     (tx_busy),
    .tx_data     (tx_data),
    .new_tx_data (new_tx_data)
  );

endmodule

`default_nettype wire

// ==== msg_sender.sv ====
// Status line sender
// Freezes a snapshot on the report tick and streams the 32-character
// line to the bridge one byte at a time, holding off while tx_busy
`timescale 1ns/1ps
`default_nettype none

module msg_sender (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            tick,
  input  logic [dbg_pkg::TS_DIGITS*8-1:0] ts_ascii,
  input  logic [dbg_pkg::ACC_WIDTH-1:0]   acc,
  input  dbg_pkg::status_t                status,
  input  logic                            tx_busy,
  output logic [7:0]                      tx_data,
  output logic                            new_tx_data
);

  import dbg_pkg::*;

  // Where the two acc bytes start in the line
  localparam logic [MSG_ADDR_BITS-1:0] ACC_HI_POS = 5'd14;
  localparam logic [MSG_ADDR_BITS-1:0] ACC_LO_POS = 5'd23;

  send_state_e              state;
  logic [MSG_ADDR_BITS-1:0] idx;
  snapshot_t                snap;
  logic                     last_char;
  logic [3:0]               hi_pos;
  logic [3:0]               lo_pos;

  // Selected digit of the frozen timestamp
  function automatic logic [7:0] ts_digit(input snapshot_t s, input int d);
    return s.ts_ascii[d*8 +: 8];
  endfunction

  // One acc bit as an ASCII character
  function automatic logic [7:0] bit_char(input logic b);
    return b ? "1" : "0";
  endfunction

  assign last_char = (idx == MSG_ADDR_BITS'(MSG_LEN - 1));

  // Byte goes out whenever the bridge can take it
  assign new_tx_data = (state == SEND_MSG) && !tx_busy;

  // Acc bit for the current index, MSB first in each byte
  assign hi_pos = 4'(ACC_HI_POS + 5'd15 - idx);
  assign lo_pos = 4'(ACC_LO_POS + 5'd7 - idx);

  // Character layout of the line
  always_comb begin
    tx_data = " ";
    case (idx) inside
      5'd1:  tx_data = snap.status.motor_armed ? "A" : "D";
      5'd3:  tx_data = snap.status.logging ? "R" : "I";
      5'd5:  tx_data = "T";
      5'd6:  tx_data = ":";
      // Seconds and tenths from the timestamp digits
      5'd8:  tx_data = ts_digit(snap, 5);
      5'd9:  tx_data = ts_digit(snap, 4);
      5'd10: tx_data = ts_digit(snap, 3);
      5'd11: tx_data = ".";
      5'd12: tx_data = ts_digit(snap, 2);
      [ACC_HI_POS : ACC_HI_POS + 5'd7]: tx_data = bit_char(snap.acc[hi_pos]);
      [ACC_LO_POS : ACC_LO_POS + 5'd7]: tx_data = bit_char(snap.acc[lo_pos]);
      5'd31: tx_data = "\r";
      default: tx_data = " ";  // Separators
    endcase
  end

  // Line FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= SEND_IDLE;
      idx   <= '0;
    end else begin
      case (state)
        SEND_IDLE: begin
          idx <= '0;
          if (tick) begin
            state <= SEND_MSG;
          end
        end
        SEND_MSG: begin
          // Ticks here are ignored
          if (!tx_busy) begin
            idx <= idx + 1'b1;
            if (last_char) begin
              state <= SEND_IDLE;
            end
          end
        end
        default: state <= SEND_IDLE;
      endcase
    end
  end

  // Snapshot so a line never mixes two reports
  always_ff @(posedge clk) begin
    if ((state == SEND_IDLE) && tick) begin
      snap <= '{status: status, ts_ascii: ts_ascii, acc: acc};
    end
  end

endmodule

`default_nettype wire

// ==== cmd_decoder.sv ====
// Command decoder
// Turns strobed bytes from the bridge into motor/logging toggles
// and a one-cycle board reset pulse
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder (
  input  logic             clk,
  input  logic             rst,
  input  logic [7:0]       rx_data,
  input  logic             new_rx_data,
  output dbg_pkg::status_t status,
  output logic             board_reset
);

  import dbg_pkg::*;

  cmd_state_e state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= CMD_IDLE;
      status      <= '0;
      board_reset <= 1'b0;
    end else begin
      // Pulse only for the cycle after the action state
      board_reset <= 1'b0;
      case (state)
        CMD_IDLE: begin
          // Unknown bytes fall through and are dropped
          if (new_rx_data) begin
            case (rx_data)
              CMD_RESET: state <= CMD_DO_RESET;
              CMD_MOTOR: state <= CMD_DO_MOTOR;
              CMD_DATA:  state <= CMD_DO_DATA;
              default:   state <= CMD_IDLE;
            endcase
          end
        end
        CMD_DO_RESET: begin
          board_reset <= 1'b1;
          state       <= CMD_IDLE;
        end
        // Arm/disarm
        CMD_DO_MOTOR: begin
          status.motor_armed <= ~status.motor_armed;
          state              <= CMD_IDLE;
        end
        // Record/idle
        CMD_DO_DATA: begin
          status.logging <= ~status.logging;
          state          <= CMD_IDLE;
        end
        default: state <= CMD_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== report_timer.sv ====
// Report timer
// Periodic one-cycle report tick plus a saturating timestamp that
// counts TS_CYCLES periods since reset
`timescale 1ns/1ps
`default_nettype none

module report_timer #(
  parameter int REPORT_CYCLES = 400,
  parameter int TS_CYCLES     = 4
) (
  input  logic                         clk,
  input  logic                         rst,
  output logic                         tick,
  output logic [dbg_pkg::TS_WIDTH-1:0] timestamp
);

  import dbg_pkg::*;

  // Counter widths, at least one bit
  localparam int REP_W = (REPORT_CYCLES > 1) ? $clog2(REPORT_CYCLES) : 1;
  localparam int TS_W  = (TS_CYCLES > 1) ? $clog2(TS_CYCLES) : 1;

  logic [REP_W-1:0] rep_cnt;
  logic [TS_W-1:0]  ts_cnt;
  logic             ts_wrap;

  // Tick while sitting on the last count
  assign tick    = (rep_cnt == REP_W'(REPORT_CYCLES - 1));
  assign ts_wrap = (ts_cnt == TS_W'(TS_CYCLES - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      rep_cnt   <= '0;
      ts_cnt    <= '0;
      timestamp <= '0;
    end else begin
      rep_cnt <= tick ? '0 : rep_cnt + 1'b1;
      ts_cnt  <= ts_wrap ? '0 : ts_cnt + 1'b1;
      // Hold at all ones instead of wrapping
      if (ts_wrap && (timestamp != {TS_WIDTH{1'b1}})) begin
        timestamp <= timestamp + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== bin_to_dec_ascii.sv ====
// Binary to ASCII decimal converter
// Combinational double dabble, one ASCII byte per decimal digit,
// least significant digit in the low byte
`timescale 1ns/1ps
`default_nettype none

module bin_to_dec_ascii #(
  parameter int BITS   = 24,
  parameter int DIGITS = 8
) (
  input  logic [BITS-1:0]     bin,
  output logic [DIGITS*8-1:0] ascii
);

  // Packed BCD, digit d in bits [4d+3:4d]
  logic [DIGITS*4-1:0] bcd;

  // Shift-and-add-3, one pass per input bit, MSB first
  always_comb begin
    bcd = '0;
    for (int i = BITS - 1; i >= 0; i--) begin
      // Digits of 5 or more would overflow on the shift
      for (int d = 0; d < DIGITS; d++) begin
        if (bcd[d*4 +: 4] >= 4'd5) begin
          bcd[d*4 +: 4] = bcd[d*4 +: 4] + 4'd3;
        end
      end
      // Shift next binary bit into the bottom digit
      bcd = {bcd[DIGITS*4-2:0], bin[i]};
    end
  end

  // BCD digit to ASCII '0'..'9'
  for (genvar d = 0; d < DIGITS; d++) begin : g_ascii
    assign ascii[d*8 +: 8] = 8'h30 + {4'h0, bcd[d*4 +: 4]};
  end

endmodule

`default_nettype wire

// ==== dbg_pkg.sv ====
// Debug terminal shared definitions
// Widths, command bytes, FSM state encodings and status/snapshot types
`default_nettype none

package dbg_pkg;

  // Timestamp counter width
  localparam int TS_WIDTH = 24;

  // Accelerometer sample width
  localparam int ACC_WIDTH = 16;

  // Decimal digits from the timestamp, enough for 2^24-1
  localparam int TS_DIGITS = 8;

  // Status line length in characters, ends with CR
  localparam int MSG_LEN = 32;

  // Character index width
  localparam int MSG_ADDR_BITS = 5;

  // Command bytes from the serial bridge
  localparam logic [7:0] CMD_RESET = "r";
  localparam logic [7:0] CMD_MOTOR = "m";
  localparam logic [7:0] CMD_DATA  = "d";

  // Command decoder states
  typedef enum logic [1:0] {
    CMD_IDLE     = 2'd0,
    CMD_DO_RESET = 2'd1,
    CMD_DO_MOTOR = 2'd2,
    CMD_DO_DATA  = 2'd3
  } cmd_state_e;

  // Message sender states
  typedef enum logic {
    SEND_IDLE = 1'b0,
    SEND_MSG  = 1'b1
  } send_state_e;

  // Board status bits
  typedef struct packed {
    logic motor_armed;  // 1 armed, 0 disarmed
    logic logging;      // 1 record, 0 idle
  } status_t;

  // Everything one line needs, frozen at the tick
  typedef struct packed {
    status_t                  status;
    logic [TS_DIGITS*8-1:0]   ts_ascii;  // Digit 0 in the low byte
    logic [ACC_WIDTH-1:0]     acc;
  } snapshot_t;

endpackage

`default_nettype wire
